//--- src/conv_pkg.sv
// ####################################################################
// shared widths, payload structs and constants of the convolution
// accelerator; every design file refers to these by scoped name
// ####################################################################

package conv_pkg;

  // raw widths behind the typedefs below
  localparam int CL_BITS    = 512;
  localparam int ADDR_BITS  = 58;
  localparam int COUNT_BITS = 32;
  localparam int PART_BITS  = 32;
  localparam int CPLX_BITS  = 2 * PART_BITS;

  // complex values carried by one cacheline
  localparam int LANES = CL_BITS / CPLX_BITS;

  // read tag, returned unchanged with the response
  localparam logic TAG_IMAGE  = 1'b0;
  localparam logic TAG_KERNEL = 1'b1;

  // one host cacheline
  typedef logic [CL_BITS-1:0] cl_t;

  // cacheline address, byte offset already stripped
  typedef logic [ADDR_BITS-1:0] addr_t;

  // number of lines or groups
  typedef logic [COUNT_BITS-1:0] count_t;

  // real or imaginary part, wraps on overflow
  typedef logic [PART_BITS-1:0] part_t;

  // re sits in the lower half of each 64-bit lane slot
  typedef struct packed {
    part_t im;
    part_t re;
  } cplx_t;

  typedef struct packed {
    addr_t addr;
    logic  tag;
  } rd_req_t;

  typedef struct packed {
    addr_t addr;
    cl_t   data;
  } wr_req_t;

  // run configuration, sampled with start
  typedef struct packed {
    addr_t  image_addr;
    addr_t  kernel_addr;
    addr_t  dest_addr;
    count_t num_in_maps;
    count_t num_groups;
  } conv_cfg_t;

endpackage

//--- src/read_requester.sv
// ####################################################################
// read request sequencer: kernel lines first, then image lines group
// by group, all gated by the host almost-full flag
// ####################################################################

module read_requester (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  conv_pkg::conv_cfg_t cfg,
  input  logic                kernel_ready,
  input  logic                rd_req_almostfull,
  output conv_pkg::rd_req_t   rd_req,
  output logic                rd_req_en
);

  typedef enum logic [2:0] {
    idle,
    kernel,
    wait_kernel,
    image,
    finished
  } state_t;

  state_t              state;
  conv_pkg::conv_cfg_t cfg_q;
  conv_pkg::addr_t     addr_q;
  conv_pkg::count_t    line_cnt;
  conv_pkg::count_t    group_cnt;
  logic                issue;
  logic                last_line;
  logic                last_group;

  // a request goes out only in a fetch state with room on the channel
  assign issue      = !rd_req_almostfull && (state == kernel || state == image);
  assign last_line  = (line_cnt == cfg_q.num_in_maps - 1);
  assign last_group = (group_cnt == cfg_q.num_groups - 1);

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= idle;
      rd_req_en <= 1'b0;
    end else begin
      rd_req_en <= issue;
      case (state)
        idle, finished: begin
          if (start) begin
            cfg_q    <= cfg;
            addr_q   <= cfg.kernel_addr;
            line_cnt <= '0;
            state    <= kernel;
          end
        end
        kernel: begin
          if (issue) begin
            addr_q   <= addr_q + 1'b1;
            line_cnt <= line_cnt + 1'b1;
            if (last_line) begin
              state <= wait_kernel;
            end
          end
        end
        wait_kernel: begin
          // image lines need the whole kernel set in memory
          if (kernel_ready) begin
            addr_q    <= cfg_q.image_addr;
            line_cnt  <= '0;
            group_cnt <= '0;
            state     <= image;
          end
        end
        image: begin
          if (issue) begin
            addr_q <= addr_q + 1'b1;
            if (last_line) begin
              line_cnt  <= '0;
              group_cnt <= group_cnt + 1'b1;
              if (last_group) begin
                state <= finished;
              end
            end else begin
              line_cnt <= line_cnt + 1'b1;
            end
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      rd_req.addr <= addr_q;
      rd_req.tag  <= (state == kernel) ? conv_pkg::TAG_KERNEL : conv_pkg::TAG_IMAGE;
    end
  end

  // host sees almost-full one cycle late at most
  a_rd_backpressure: assert property (
    @(posedge clk) disable iff (reset) rd_req_almostfull |=> !rd_req_en
  );

endmodule

//--- src/kernel_feeder.sv
// ####################################################################
// steers read responses by tag: kernel lines into a local memory,
// image lines paired with their kernel line and split into lanes
// ####################################################################

module kernel_feeder #(
  parameter int KERNEL_DEPTH_BITS = 6
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  conv_pkg::count_t num_in_maps,
  input  logic             rd_rsp_valid,
  input  logic             rd_rsp_tag,
  input  conv_pkg::cl_t    rd_rsp_data,
  output logic             kernel_ready,
  output logic             lane_strobe,
  output logic             lane_last,
  output conv_pkg::cplx_t  image_val [conv_pkg::LANES],
  output conv_pkg::cplx_t  kernel_val [conv_pkg::LANES]
);

  localparam int KERNEL_LINES = 2 ** KERNEL_DEPTH_BITS;

  conv_pkg::cl_t    kernel_mem [KERNEL_LINES];
  conv_pkg::cl_t    kernel_line_q;
  conv_pkg::cl_t    image_line_q;
  conv_pkg::count_t maps_q;
  conv_pkg::count_t kernel_cnt;
  conv_pkg::count_t image_idx;
  logic             kernel_we;
  logic             image_in;
  logic             image_wrap;

  assign kernel_we  = rd_rsp_valid && rd_rsp_tag == conv_pkg::TAG_KERNEL;
  assign image_in   = rd_rsp_valid && rd_rsp_tag == conv_pkg::TAG_IMAGE;
  // kernel index wraps at num_in_maps, which is also the group boundary
  assign image_wrap = (image_idx == maps_q - 1);

  always_ff @(posedge clk) begin
    if (reset) begin
      kernel_ready <= 1'b0;
      kernel_cnt   <= '0;
      image_idx    <= '0;
      lane_strobe  <= 1'b0;
      lane_last    <= 1'b0;
    end else begin
      lane_strobe <= image_in;
      lane_last   <= image_in && image_wrap;
      if (start) begin
        maps_q       <= num_in_maps;
        kernel_ready <= 1'b0;
        kernel_cnt   <= '0;
        image_idx    <= '0;
      end else begin
        if (kernel_we) begin
          kernel_cnt <= kernel_cnt + 1'b1;
          if (kernel_cnt + 1'b1 == maps_q) begin
            kernel_ready <= 1'b1;
          end
        end
        if (image_in) begin
          image_idx <= image_wrap ? '0 : image_idx + 1'b1;
        end
      end
    end
  end

  // memory write and registered read, aligned with the image register
  always_ff @(posedge clk) begin
    if (kernel_we) begin
      kernel_mem[kernel_cnt[KERNEL_DEPTH_BITS-1:0]] <= rd_rsp_data;
    end
    if (image_in) begin
      kernel_line_q <= kernel_mem[image_idx[KERNEL_DEPTH_BITS-1:0]];
      image_line_q  <= rd_rsp_data;
    end
  end

  always_comb begin
    for (int n = 0; n < conv_pkg::LANES; n++) begin
      image_val[n]  = image_line_q[n*conv_pkg::CPLX_BITS +: conv_pkg::CPLX_BITS];
      kernel_val[n] = kernel_line_q[n*conv_pkg::CPLX_BITS +: conv_pkg::CPLX_BITS];
    end
  end

  // the requester must hold image reads until the kernel set is stored
  a_image_after_kernel: assert property (
    @(posedge clk) disable iff (reset) image_in |-> kernel_ready
  );

endmodule

//--- src/cmac_lane.sv
// ####################################################################
// one complex multiply-accumulate lane; a product stage feeds an
// accumulator that restarts on the first product of every group
// ####################################################################

module cmac_lane (
  input  logic            clk,
  input  logic            reset,
  input  logic            strobe,
  input  logic            last,
  input  conv_pkg::cplx_t image_val,
  input  conv_pkg::cplx_t kernel_val,
  output logic            sum_valid,
  output conv_pkg::cplx_t sum
);

  conv_pkg::cplx_t prod;
  logic            prod_valid;
  logic            prod_last;
  logic            acc_first;

  // product stage with 32-bit wrapping arithmetic
  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid <= 1'b0;
    end else begin
      prod_valid <= strobe;
    end
    prod_last <= last;
    prod.re   <= image_val.re * kernel_val.re - image_val.im * kernel_val.im;
    prod.im   <= image_val.re * kernel_val.im + image_val.im * kernel_val.re;
  end

  // sum holds the group total while sum_valid is high
  always_ff @(posedge clk) begin
    if (reset) begin
      sum_valid <= 1'b0;
      acc_first <= 1'b1;
    end else begin
      sum_valid <= prod_valid && prod_last;
      if (prod_valid) begin
        acc_first <= prod_last;
      end
    end
    if (prod_valid) begin
      if (acc_first) begin
        sum <= prod;
      end else begin
        sum.re <= sum.re + prod.re;
        sum.im <= sum.im + prod.im;
      end
    end
  end

endmodule

//--- src/result_writer.sv
// ####################################################################
// packs lane sums into a cacheline, buffers it in the output FIFO and
// issues write requests at consecutive destination lines, then done
// ####################################################################

module result_writer #(
  parameter int FIFO_DEPTH_BITS = 3
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  conv_pkg::conv_cfg_t cfg,
  input  logic                sum_valid,
  input  conv_pkg::cplx_t     sums [conv_pkg::LANES],
  input  logic                wr_req_almostfull,
  output conv_pkg::wr_req_t   wr_req,
  output logic                wr_req_en,
  output logic                done
);

  localparam int FIFO_DEPTH = 2 ** FIFO_DEPTH_BITS;

  conv_pkg::cl_t               fifo_mem [FIFO_DEPTH];
  logic [FIFO_DEPTH_BITS-1:0]  wr_ptr;
  logic [FIFO_DEPTH_BITS-1:0]  rd_ptr;
  logic [FIFO_DEPTH_BITS:0]    fill;
  logic                        fifo_empty;
  logic                        fifo_full;
  logic                        pop;
  conv_pkg::cl_t               packed_line;
  conv_pkg::addr_t             dest_q;
  conv_pkg::count_t            groups_q;
  conv_pkg::count_t            wr_cnt;
  logic                        active;

  always_comb begin
    for (int n = 0; n < conv_pkg::LANES; n++) begin
      packed_line[n*conv_pkg::CPLX_BITS +: conv_pkg::CPLX_BITS] = sums[n];
    end
  end

  assign fifo_empty = (fill == '0);
  assign fifo_full  = (fill == FIFO_DEPTH);
  assign pop        = !fifo_empty && !wr_req_almostfull;

  // FIFO pointers and run bookkeeping
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      fill      <= '0;
      wr_req_en <= 1'b0;
      done      <= 1'b0;
      active    <= 1'b0;
      wr_cnt    <= '0;
    end else begin
      wr_req_en <= pop;
      if (sum_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
        wr_cnt <= wr_cnt + 1'b1;
      end
      fill <= fill + sum_valid - pop;
      if (start && !active) begin
        dest_q   <= cfg.dest_addr;
        groups_q <= cfg.num_groups;
        wr_cnt   <= '0;
        active   <= 1'b1;
        done     <= 1'b0;
      end else if (active && wr_req_en && wr_cnt == groups_q) begin
        // last request of the run just left
        active <= 1'b0;
        done   <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sum_valid) begin
      fifo_mem[wr_ptr] <= packed_line;
    end
    if (pop) begin
      wr_req.data <= fifo_mem[rd_ptr];
      wr_req.addr <= dest_q + conv_pkg::addr_t'(wr_cnt);
    end
  end

  // write almost-full pulses must stay short enough for the lanes
  a_fifo_overflow: assert property (
    @(posedge clk) disable iff (reset) sum_valid |-> (!fifo_full || pop)
  );

endmodule

//--- src/conv_afu_top.sv
// ####################################################################
// accelerator top: read requester, kernel feeder, the lane array and
// the result writer between the host read and write channels
// ####################################################################

module conv_afu_top #(
  parameter int KERNEL_DEPTH_BITS = 6,
  parameter int FIFO_DEPTH_BITS   = 3
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  conv_pkg::conv_cfg_t cfg,
  output conv_pkg::rd_req_t   rd_req,
  output logic                rd_req_en,
  input  logic                rd_req_almostfull,
  input  logic                rd_rsp_valid,
  input  logic                rd_rsp_tag,
  input  conv_pkg::cl_t       rd_rsp_data,
  output conv_pkg::wr_req_t   wr_req,
  output logic                wr_req_en,
  input  logic                wr_req_almostfull,
  output logic                done
);

  logic                       kernel_ready;
  logic                       lane_strobe;
  logic                       lane_last;
  conv_pkg::cplx_t            image_val [conv_pkg::LANES];
  conv_pkg::cplx_t            kernel_val [conv_pkg::LANES];
  conv_pkg::cplx_t            lane_sum [conv_pkg::LANES];
  logic [conv_pkg::LANES-1:0] lane_sum_valid;

  read_requester i_read_requester (
    .clk              (clk),
    .reset            (reset),
    .start            (start),
    .cfg              (cfg),
    .kernel_ready     (kernel_ready),
    .rd_req_almostfull(rd_req_almostfull),
    .rd_req           (rd_req),
    .rd_req_en        (rd_req_en)
  );

  kernel_feeder #(
    .KERNEL_DEPTH_BITS(KERNEL_DEPTH_BITS)
  ) i_kernel_feeder (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .num_in_maps (cfg.num_in_maps),
    .rd_rsp_valid(rd_rsp_valid),
    .rd_rsp_tag  (rd_rsp_tag),
    .rd_rsp_data (rd_rsp_data),
    .kernel_ready(kernel_ready),
    .lane_strobe (lane_strobe),
    .lane_last   (lane_last),
    .image_val   (image_val),
    .kernel_val  (kernel_val)
  );

  for (genvar n = 0; n < conv_pkg::LANES; n++) begin : g_lane
    cmac_lane i_cmac_lane (
      .clk       (clk),
      .reset     (reset),
      .strobe    (lane_strobe),
      .last      (lane_last),
      .image_val (image_val[n]),
      .kernel_val(kernel_val[n]),
      .sum_valid (lane_sum_valid[n]),
      .sum       (lane_sum[n])
    );
  end

  // lanes run in lockstep, so their valid strobes coincide
  result_writer #(
    .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)
  ) i_result_writer (
    .clk              (clk),
    .reset            (reset),
    .start            (start),
    .cfg              (cfg),
    .sum_valid        (&lane_sum_valid),
    .sums             (lane_sum),
    .wr_req_almostfull(wr_req_almostfull),
    .wr_req           (wr_req),
    .wr_req_en        (wr_req_en),
    .done             (done)
  );

endmodule

//--- test/host_mem_model.sv
// ####################################################################
// host memory model: answers tagged reads in order after a random
// delay, drives random almost-full and logs every read and write
// ####################################################################

module host_mem_model #(
  parameter int SEED = 1
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              rd_af_on,
  input  logic              wr_af_on,
  input  conv_pkg::rd_req_t rd_req,
  input  logic              rd_req_en,
  output logic              rd_req_almostfull = 1'b0,
  output logic              rd_rsp_valid = 1'b0,
  output logic              rd_rsp_tag = 1'b0,
  output conv_pkg::cl_t     rd_rsp_data = '0,
  input  conv_pkg::wr_req_t wr_req,
  input  logic              wr_req_en,
  output logic              wr_req_almostfull = 1'b0
);
  timeunit 1ns;
  timeprecision 1ps;

  integer            seed = SEED;
  conv_pkg::cl_t     mem [conv_pkg::addr_t];
  conv_pkg::rd_req_t pend [$];
  conv_pkg::rd_req_t rd_log [$];
  conv_pkg::wr_req_t wr_log [$];
  conv_pkg::rd_req_t req;
  int                delay = 0;

  always @(posedge clk) begin
    if (reset) begin
      rd_rsp_valid      <= 1'b0;
      rd_req_almostfull <= 1'b0;
      wr_req_almostfull <= 1'b0;
      delay = 0;
    end else begin
      if (rd_req_en) begin
        pend.push_back(rd_req);
        rd_log.push_back(rd_req);
      end
      if (wr_req_en) begin
        wr_log.push_back(wr_req);
      end
      // one response per cycle at most, in request order
      rd_rsp_valid <= 1'b0;
      if (delay > 0) begin
        delay = delay - 1;
      end else if (pend.size() > 0) begin
        req = pend.pop_front();
        rd_rsp_valid <= 1'b1;
        rd_rsp_tag   <= req.tag;
        rd_rsp_data  <= mem.exists(req.addr) ? mem[req.addr] : '0;
        delay = $random(seed) & 3;
      end
      // write pulses stay short so the output FIFO keeps room
      rd_req_almostfull <= rd_af_on && (($random(seed) & 3) == 0);
      wr_req_almostfull <= wr_af_on && (($random(seed) & 7) < 3);
    end
  end

endmodule

//--- test/conv_afu_tb.sv
// ####################################################################
// directed testbench for the convolution accelerator; runs each test
// task against the host model and prints an error summary at the end
// ####################################################################

module conv_afu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SEED        = 4184;
  localparam int RUN_TIMEOUT = 2000;

  logic                clk = 1'b0;
  logic                reset = 1'b1;
  logic                start = 1'b0;
  conv_pkg::conv_cfg_t cfg = '0;
  logic                rd_af_on = 1'b0;
  logic                wr_af_on = 1'b0;
  conv_pkg::rd_req_t   rd_req;
  logic                rd_req_en;
  logic                rd_req_almostfull;
  logic                rd_rsp_valid;
  logic                rd_rsp_tag;
  conv_pkg::cl_t       rd_rsp_data;
  conv_pkg::wr_req_t   wr_req;
  logic                wr_req_en;
  logic                wr_req_almostfull;
  logic                done;
  logic                rd_af_seen = 1'b0;
  logic                wr_af_seen = 1'b0;
  integer              seed = SEED;
  int                  value_errors = 0;
  int                  other_errors = 0;
  conv_pkg::cl_t       host_lines [conv_pkg::addr_t];

  initial begin
    forever #2 clk = ~clk;
  end

  conv_afu_top i_conv_afu_top (
    .clk              (clk),
    .reset            (reset),
    .start            (start),
    .cfg              (cfg),
    .rd_req           (rd_req),
    .rd_req_en        (rd_req_en),
    .rd_req_almostfull(rd_req_almostfull),
    .rd_rsp_valid     (rd_rsp_valid),
    .rd_rsp_tag       (rd_rsp_tag),
    .rd_rsp_data      (rd_rsp_data),
    .wr_req           (wr_req),
    .wr_req_en        (wr_req_en),
    .wr_req_almostfull(wr_req_almostfull),
    .done             (done)
  );

  host_mem_model #(
    .SEED(SEED)
  ) i_host_mem_model (
    .clk              (clk),
    .reset            (reset),
    .rd_af_on         (rd_af_on),
    .wr_af_on         (wr_af_on),
    .rd_req           (rd_req),
    .rd_req_en        (rd_req_en),
    .rd_req_almostfull(rd_req_almostfull),
    .rd_rsp_valid     (rd_rsp_valid),
    .rd_rsp_tag       (rd_rsp_tag),
    .rd_rsp_data      (rd_rsp_data),
    .wr_req           (wr_req),
    .wr_req_en        (wr_req_en),
    .wr_req_almostfull(wr_req_almostfull)
  );

  task automatic check_addr(input string name, input conv_pkg::addr_t got,
                            input conv_pkg::addr_t exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_line(input string name, input conv_pkg::cl_t got,
                            input conv_pkg::cl_t exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  // an enable may not follow a cycle in which almost-full was high
  always @(negedge clk) begin
    if (!reset) begin
      if (rd_af_seen) begin
        check_bit("rd_req_en", rd_req_en, 1'b0);
      end
      if (wr_af_seen) begin
        check_bit("wr_req_en", wr_req_en, 1'b0);
      end
    end
    rd_af_seen = rd_req_almostfull;
    wr_af_seen = wr_req_almostfull;
  end

  function automatic conv_pkg::conv_cfg_t make_cfg(input conv_pkg::addr_t img,
      input conv_pkg::addr_t ker, input conv_pkg::addr_t dest, input int maps,
      input int groups);
    conv_pkg::conv_cfg_t c;
    c.image_addr  = img;
    c.kernel_addr = ker;
    c.dest_addr   = dest;
    c.num_in_maps = conv_pkg::count_t'(maps);
    c.num_groups  = conv_pkg::count_t'(groups);
    return c;
  endfunction

  // group g sums image line g*maps+i times kernel line i, lane by lane
  function automatic conv_pkg::cl_t expected_line(input conv_pkg::conv_cfg_t c, input int g);
    conv_pkg::cl_t   line;
    conv_pkg::cl_t   img;
    conv_pkg::cl_t   ker;
    conv_pkg::cplx_t a;
    conv_pkg::cplx_t b;
    conv_pkg::cplx_t acc;
    int              maps;
    maps = int'(c.num_in_maps);
    line = '0;
    for (int n = 0; n < conv_pkg::LANES; n++) begin
      acc = '0;
      for (int i = 0; i < maps; i++) begin
        img = host_lines[c.image_addr + conv_pkg::addr_t'(g * maps + i)];
        ker = host_lines[c.kernel_addr + conv_pkg::addr_t'(i)];
        a = img[n*64 +: 64];
        b = ker[n*64 +: 64];
        acc.re = acc.re + (a.re * b.re - a.im * b.im);
        acc.im = acc.im + (a.re * b.im + a.im * b.re);
      end
      line[n*64 +: 64] = acc;
    end
    return line;
  endfunction

  task automatic preload(input conv_pkg::addr_t base, input int lines);
    conv_pkg::cl_t line;
    for (int i = 0; i < lines; i++) begin
      for (int k = 0; k < 16; k++) begin
        line[32*k +: 32] = $random(seed);
      end
      host_lines[base + conv_pkg::addr_t'(i)] = line;
      i_host_mem_model.mem[base + conv_pkg::addr_t'(i)] = line;
    end
  endtask

  task automatic run_conv(input conv_pkg::conv_cfg_t c, input logic rd_bp, input logic wr_bp);
    int                rd_base;
    int                wr_base;
    int                cycles;
    int                maps;
    int                groups;
    conv_pkg::rd_req_t r;
    conv_pkg::wr_req_t w;
    maps    = int'(c.num_in_maps);
    groups  = int'(c.num_groups);
    rd_base = i_host_mem_model.rd_log.size();
    wr_base = i_host_mem_model.wr_log.size();
    preload(c.kernel_addr, maps);
    preload(c.image_addr, maps * groups);
    @(posedge clk);
    rd_af_on <= rd_bp;
    wr_af_on <= wr_bp;
    start    <= 1'b1;
    cfg      <= c;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    check_bit("done", done, 1'b0);
    cycles = 0;
    while (!done && cycles < RUN_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!done) begin
      $display("timeout: done did not rise within %0d cycles", RUN_TIMEOUT);
      other_errors++;
    end
    @(posedge clk);
    rd_af_on <= 1'b0;
    wr_af_on <= 1'b0;
    // kernel reads first, then image reads, each at consecutive lines
    if (i_host_mem_model.rd_log.size() - rd_base != maps + maps * groups) begin
      $display("wrong number of read requests: %0d instead of %0d",
               i_host_mem_model.rd_log.size() - rd_base, maps + maps * groups);
      other_errors++;
    end else begin
      for (int k = 0; k < maps + maps * groups; k++) begin
        r = i_host_mem_model.rd_log[rd_base + k];
        if (k < maps) begin
          check_bit("rd_req.tag", r.tag, conv_pkg::TAG_KERNEL);
          check_addr("rd_req.addr", r.addr, c.kernel_addr + conv_pkg::addr_t'(k));
        end else begin
          check_bit("rd_req.tag", r.tag, conv_pkg::TAG_IMAGE);
          check_addr("rd_req.addr", r.addr, c.image_addr + conv_pkg::addr_t'(k - maps));
        end
      end
    end
    if (i_host_mem_model.wr_log.size() - wr_base != groups) begin
      $display("wrong number of write requests: %0d instead of %0d",
               i_host_mem_model.wr_log.size() - wr_base, groups);
      other_errors++;
    end else begin
      for (int g = 0; g < groups; g++) begin
        w = i_host_mem_model.wr_log[wr_base + g];
        check_addr("wr_req.addr", w.addr, c.dest_addr + conv_pkg::addr_t'(g));
        check_line("wr_req.data", w.data, expected_line(c, g));
      end
    end
  endtask

  task automatic test_reset();
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      check_bit("rd_req_en", rd_req_en, 1'b0);
      check_bit("wr_req_en", wr_req_en, 1'b0);
      check_bit("done", done, 1'b0);
    end
  endtask

  task automatic test_single_map();
    run_conv(make_cfg('h1000, 'h0100, 'h8000, 1, 2), 1'b0, 1'b0);
  endtask

  task automatic test_accumulate();
    run_conv(make_cfg('h2000, 'h0200, 'h9000, 4, 3), 1'b0, 1'b0);
  endtask

  task automatic test_read_backpressure();
    run_conv(make_cfg('h3000, 'h0300, 'ha000, 3, 3), 1'b1, 1'b0);
  endtask

  // one map per group gives the highest write rate
  task automatic test_write_backpressure();
    run_conv(make_cfg('h4000, 'h0400, 'hb000, 1, 3), 1'b0, 1'b1);
  endtask

  task automatic test_second_run();
    run_conv(make_cfg('h5000, 'h0500, 'hc000, 2, 2), 1'b0, 1'b0);
    run_conv(make_cfg('h6000, 'h0600, 'hd000, 5, 2), 1'b1, 1'b1);
  endtask

  initial begin
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    test_reset();
    test_single_map();
    test_accumulate();
    test_read_backpressure();
    test_write_backpressure();
    test_second_run();
    $display("error summary: %0d value mismatches, %0d other failures",
             value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
src/conv_pkg.sv
src/read_requester.sv
src/kernel_feeder.sv
src/cmac_lane.sv
src/result_writer.sv
src/conv_afu_top.sv
test/host_mem_model.sv
test/conv_afu_tb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and decide the result from the log
rm -f sim.log \
  && verilator --binary --timing --assert --timescale 1ns/1ps \
       -f flist.f --top-module conv_afu_tb -o sim_conv_afu \
  && ./obj_dir/sim_conv_afu | tee sim.log \
  && grep -q "TESTBENCH PASSED" sim.log \
  || { echo "simulation did not pass"; exit 1; }
